// File: project.f
div_pkg.sv
div_issue.sv
div_req_fifo.sv
div_core.sv
div_unit.sv
tb_clk_gen.sv
tb_div_unit.sv

// File: Makefile
# Verilator build and run for the divide unit testbench

VERILATOR  ?= verilator
TOP        ?= tb_div_unit
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
SEED_FLAGS ?= -GSEED=78659
VFLAGS     ?= --binary --timing --assert -j 0

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(SEED_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the log, not the exit status
run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_div_unit.sv
`timescale 1ns/1ps

module tb_div_unit #(
    parameter logic [63:0] SEED = 64'd78659
);
    import div_pkg::*;

    // cycles any single wait may take
    localparam int TIMEOUT = 2000;
    localparam int N_RAND  = 40;
    // zero, minus one, most negative, and 32-bit edges
    localparam logic [63:0] CORNERS [8] = '{
        64'h0, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000, 64'h1,
        64'h0000_0000_7fff_ffff, 64'h0000_0000_8000_0000, 64'h0000_0000_ffff_ffff,
        64'hffff_ffff_8000_0000
    };

    logic                 clk;
    logic                 rst;
    logic                 req_valid;
    logic                 req_ready;
    logic [2:0]           req_funct3;
    logic                 req_word;
    logic [TAG_W-1:0]     req_tag;
    logic [XLEN-1:0]      req_rs1;
    logic [XLEN-1:0]      req_rs2;
    logic                 rsp_valid;
    logic                 rsp_ready;
    logic [TAG_W-1:0]     rsp_tag;
    logic [XLEN-1:0]      rsp_data;

    // scoreboard, {tag, result} per accepted request
    logic [TAG_W+XLEN-1:0] exp_q [$];
    logic [TAG_W+XLEN-1:0] exp_head = '0;
    int                    exp_cnt  = 0;
    logic [63:0]           op_state;
    logic [63:0]           rdy_state;
    logic [TAG_W-1:0]      next_tag;
    logic                  bp_mode;
    logic                  saw_stall;
    string                 test_name;

    tb_clk_gen u_clk (
        .clk (clk)
    );

    div_unit uut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_funct3 (req_funct3),
        .req_word   (req_word),
        .req_tag    (req_tag),
        .req_rs1    (req_rs1),
        .req_rs2    (req_rs2),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_tag    (rsp_tag),
        .rsp_data   (rsp_data)
    );

    task automatic stop_fail(input string msg);
        $display("%s (test %s)", msg, test_name);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] exp,
            input logic [63:0] act);
        stop_fail($sformatf("** Error: %s %s expected %h actual %h", test_name, what, exp, act));
    endtask

    // 64-bit LCG, Knuth constants
    function automatic logic [63:0] lcg_step(input logic [63:0] s);
        return s * 64'd6364136223846793005 + 64'd1442695040888963407;
    endfunction

    // corner value, a shifted-down small value, or a full random word
    function automatic logic [63:0] pick_operand();
        op_state = lcg_step(op_state);
        case (op_state[63:61])
            3'd0:    return CORNERS[op_state[50:48]];
            3'd1:    return {op_state[31:0], op_state[63:32]} >> op_state[59:54];
            default: return {op_state[31:0], op_state[63:32]};
        endcase
    endfunction

    // architectural result, special cases before the divide
    function automatic logic [XLEN-1:0] model_div(input logic [2:0] f3, input logic word,
            input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2);
        logic                   sgn;
        logic                   rem;
        logic signed [XLEN+1:0] a;
        logic signed [XLEN+1:0] b;
        logic signed [XLEN+1:0] r;
        logic signed [XLEN+1:0] min_v;
        // funct3 bit 0 clear means signed, bit 1 set means remainder
        sgn = !f3[0];
        rem = f3[1];
        if (word) begin
            a     = sgn ? {{34{rs1[31]}}, rs1[31:0]} : {34'b0, rs1[31:0]};
            b     = sgn ? {{34{rs2[31]}}, rs2[31:0]} : {34'b0, rs2[31:0]};
            min_v = {{35{1'b1}}, 31'b0};
        end else begin
            a     = sgn ? {{2{rs1[63]}}, rs1} : {2'b0, rs1};
            b     = sgn ? {{2{rs2[63]}}, rs2} : {2'b0, rs2};
            min_v = {{3{1'b1}}, 63'b0};
        end
        if (b == '0) begin
            r = rem ? a : '1;
        end else if (sgn && a == min_v && b == '1) begin
            r = rem ? '0 : a;
        end else begin
            r = rem ? a % b : a / b;
        end
        return word ? {{32{r[31]}}, r[31:0]} : r[63:0];
    endfunction

    // entered 2 ns after an edge, leaves 2 ns after the accepting edge
    task automatic send_req(input logic [2:0] f3, input logic word,
            input logic [63:0] a, input logic [63:0] b);
        int waited;
        waited     = 0;
        req_valid  = 1'b1;
        req_funct3 = f3;
        req_word   = word;
        req_tag    = next_tag;
        req_rs1    = a;
        req_rs2    = b;
        #1;
        // req_ready does not depend on req_valid, stable here
        while (!req_ready) begin
            saw_stall = 1'b1;
            waited++;
            if (waited > TIMEOUT) begin
                stop_fail("request was not accepted before the timeout");
            end
            @(posedge clk);
            #3;
        end
        exp_q.push_back({next_tag, model_div(f3, word, a, b)});
        next_tag = next_tag + 1'b1;
        @(posedge clk);
        #2;
    endtask

    task automatic wait_drain();
        int waited;
        waited    = 0;
        req_valid = 1'b0;
        while (exp_q.size() != 0) begin
            if (waited == TIMEOUT) begin
                stop_fail("outstanding responses did not drain before the timeout");
            end
            @(posedge clk);
            #2;
            waited++;
        end
    endtask

    task automatic random_ops(input logic word);
        logic [63:0] a;
        logic [63:0] b;
        for (int i = 0; i < N_RAND; i++) begin
            a = pick_operand();
            b = pick_operand();
            send_req({1'b1, op_state[40:39]}, word, a, b);
        end
    endtask

    // rsp_ready, random only in back-pressure mode
    initial begin
        logic mode;
        rsp_ready = 1'b0;
        rdy_state = ~SEED;
        forever begin
            @(posedge clk);
            mode = bp_mode;
            #2;
            rdy_state = lcg_step(rdy_state);
            rsp_ready = mode ? rdy_state[63] : 1'b1;
        end
    end

    // retire the head on each response transfer
    always @(posedge clk) begin
        if (!rst && rsp_valid && rsp_ready && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
        end
        exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
        exp_cnt  <= exp_q.size();
    end

    a_rsp_expected: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && rsp_ready |-> exp_cnt != 0)
        else stop_fail("response transfer with no request outstanding");

    a_rsp_tag: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && rsp_ready |-> rsp_tag == exp_head[XLEN +: TAG_W])
        else report_mismatch("tag", 64'($sampled(exp_head[XLEN +: TAG_W])),
            64'($sampled(rsp_tag)));

    a_rsp_data: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && rsp_ready |-> rsp_data == exp_head[XLEN-1:0])
        else report_mismatch("data", $sampled(exp_head[XLEN-1:0]), $sampled(rsp_data));

    // parked response holds until taken
    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_tag) && $stable(rsp_data))
        else stop_fail("response changed or dropped while rsp_ready was low");

    initial begin
        logic [63:0] r;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_funct3 = FUNCT3_DIV;
        req_word   = 1'b0;
        req_tag    = '0;
        req_rs1    = '0;
        req_rs2    = '0;
        op_state   = SEED;
        next_tag   = '0;
        bp_mode    = 1'b0;
        saw_stall  = 1'b0;
        test_name  = "reset";
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        assert (req_ready && !rsp_valid)
            else stop_fail("req_ready low or rsp_valid high after reset");

        test_name = "random_64";
        random_ops(1'b0);
        wait_drain();

        test_name = "random_word";
        random_ops(1'b1);
        // DIVUW with bit 31 of the quotient set
        send_req(FUNCT3_DIVU, 1'b1, 64'h1234_5678_f000_0001, 64'h1);
        wait_drain();

        // divide by zero and signed overflow, both widths, upper bits random
        test_name = "special";
        for (int f = 4; f < 8; f++) begin
            r = pick_operand();
            send_req(3'(f), 1'b0, r, 64'h0);
            send_req(3'(f), 1'b1, r, {r[31:0], 32'h0});
            send_req(3'(f), 1'b0, 64'h8000_0000_0000_0000, '1);
            send_req(3'(f), 1'b1, {r[63:32], 32'h8000_0000}, {r[31:0], 32'hffff_ffff});
        end
        wait_drain();

        test_name = "backpressure";
        bp_mode   = 1'b1;
        saw_stall = 1'b0;
        random_ops(1'b0);
        wait_drain();
        assert (saw_stall) else stop_fail("req_ready never fell under back-pressure");

        // all answered, so nothing may be parked and the issue side is open
        test_name = "final";
        if (exp_q.size() != 0 || rsp_valid || !req_ready) begin
            stop_fail("extra response left over or request side still blocked at the end");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    // free-running clock, 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

endmodule

// File: div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic [2:0]                req_funct3,
    input  logic                      req_word,
    input  logic [div_pkg::TAG_W-1:0] req_tag,
    input  logic [div_pkg::XLEN-1:0]  req_rs1,
    input  logic [div_pkg::XLEN-1:0]  req_rs2,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output logic [div_pkg::TAG_W-1:0] rsp_tag,
    output logic [div_pkg::XLEN-1:0]  rsp_data
);
    import div_pkg::*;

    // issue register outputs
    logic             iss_valid;
    logic             iss_ready;
    logic             iss_signed;
    logic             iss_rem;
    logic             iss_word;
    logic [TAG_W-1:0] iss_tag;
    logic [XLEN-1:0]  iss_rs1;
    logic [XLEN-1:0]  iss_rs2;

    // queue in and out records
    div_req_t iss_req;
    div_req_t q_req;
    logic     q_valid;
    logic     core_ready;

    div_issue u_issue (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_funct3 (req_funct3),
        .req_word   (req_word),
        .req_tag    (req_tag),
        .req_rs1    (req_rs1),
        .req_rs2    (req_rs2),
        .iss_valid  (iss_valid),
        .iss_ready  (iss_ready),
        .iss_signed (iss_signed),
        .iss_rem    (iss_rem),
        .iss_word   (iss_word),
        .iss_tag    (iss_tag),
        .iss_rs1    (iss_rs1),
        .iss_rs2    (iss_rs2)
    );

    // pack decoded fields for the queue
    assign iss_req.is_signed = iss_signed;
    assign iss_req.want_rem  = iss_rem;
    assign iss_req.is_word   = iss_word;
    assign iss_req.tag       = iss_tag;
    assign iss_req.rs1       = iss_rs1;
    assign iss_req.rs2       = iss_rs2;

    div_req_fifo #(
        .payload_t (div_req_t)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (iss_valid),
        .in_ready  (iss_ready),
        .in_data   (iss_req),
        .out_valid (q_valid),
        .out_ready (core_ready),
        .out_data  (q_req)
    );

    // head of queue unpacked straight into the divider
    div_core u_core (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (q_valid),
        .in_ready  (core_ready),
        .in_signed (q_req.is_signed),
        .in_rem    (q_req.want_rem),
        .in_word   (q_req.is_word),
        .in_tag    (q_req.tag),
        .in_rs1    (q_req.rs1),
        .in_rs2    (q_req.rs2),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_tag   (rsp_tag),
        .rsp_data  (rsp_data)
    );

endmodule

// File: div_core.sv
`timescale 1ns/1ps

module div_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic                      in_signed,
    input  logic                      in_rem,
    input  logic                      in_word,
    input  logic [div_pkg::TAG_W-1:0] in_tag,
    input  logic [div_pkg::XLEN-1:0]  in_rs1,
    input  logic [div_pkg::XLEN-1:0]  in_rs2,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output logic [div_pkg::TAG_W-1:0] rsp_tag,
    output logic [div_pkg::XLEN-1:0]  rsp_data
);
    import div_pkg::*;

    // control
    logic       busy;
    logic [6:0] cnt;
    logic       accept;
    logic       last_step;

    // latched request, 65-bit extended
    logic [XLEN:0] dvd_x;
    logic [XLEN:0] dvs_x;
    logic [XLEN:0] dvs_mag;
    logic          op_rem;
    logic          op_word;

    // partial remainder and quotient pair
    logic [XLEN:0] part_rem;
    logic [XLEN:0] quot_q;

    logic [XLEN:0]   rs1_x;
    logic [XLEN:0]   rs2_x;
    logic [XLEN:0]   rs1_mag;
    logic [XLEN:0]   rs2_mag;
    logic [XLEN:0]   rem_sh;
    logic [XLEN:0]   rem_step;
    logic [XLEN:0]   rem_fix;
    logic [XLEN:0]   quot_s;
    logic [XLEN:0]   rem_s;
    logic [XLEN:0]   min_x;
    logic            div_zero;
    logic            overflow;
    logic [XLEN:0]   res;
    logic [XLEN-1:0] res_out;

    // idle and nothing parked on the response side
    assign in_ready  = !busy && !rsp_valid;
    assign accept    = in_valid && in_ready;
    assign last_step = cnt == 7'(DIV_CYCLES - 1);

    // word ops look at the low half only
    assign rs1_x = in_word ? {{(XLEN - 31){in_signed & in_rs1[31]}}, in_rs1[31:0]}
                           : {in_signed & in_rs1[XLEN-1], in_rs1};
    assign rs2_x = in_word ? {{(XLEN - 31){in_signed & in_rs2[31]}}, in_rs2[31:0]}
                           : {in_signed & in_rs2[XLEN-1], in_rs2};
    assign rs1_mag = rs1_x[XLEN] ? -rs1_x : rs1_x;
    assign rs2_mag = rs2_x[XLEN] ? -rs2_x : rs2_x;

    // one non-restoring step, shift then add or subtract by remainder sign
    assign rem_sh   = {part_rem[XLEN-1:0], quot_q[XLEN]};
    assign rem_step = part_rem[XLEN] ? rem_sh + dvs_mag : rem_sh - dvs_mag;

    // final remainder correction
    assign rem_fix = part_rem[XLEN] ? part_rem + dvs_mag : part_rem;

    // quotient sign from both operands, remainder follows dividend
    assign quot_s = (dvd_x[XLEN] ^ dvs_x[XLEN]) ? -quot_q : quot_q;
    assign rem_s  = dvd_x[XLEN] ? -rem_fix : rem_fix;

    // most negative value at the op width, extended
    assign min_x = op_word ? {{(XLEN - 30){1'b1}}, 31'b0} : {2'b11, {(XLEN - 1){1'b0}}};

    assign div_zero = dvs_x == '0;
    // all-ones divisor only possible when signed
    assign overflow = (dvd_x == min_x) && (&dvs_x);

    always_comb begin
        if (div_zero) begin
            res = op_rem ? dvd_x : '1;
        end else if (overflow) begin
            res = op_rem ? '0 : dvd_x;
        end else begin
            res = op_rem ? rem_s : quot_s;
        end
    end

    // word result sign-extends bit 31
    assign res_out = op_word ? {{(XLEN - 32){res[31]}}, res[31:0]} : res[XLEN-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            cnt       <= '0;
            rsp_valid <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            if (last_step) begin
                busy      <= 1'b0;
                rsp_valid <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end else if (rsp_valid && rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // datapath, 65 steps then one result edge
    always_ff @(posedge clk) begin
        if (accept) begin
            dvd_x    <= rs1_x;
            dvs_x    <= rs2_x;
            dvs_mag  <= rs2_mag;
            part_rem <= '0;
            quot_q   <= rs1_mag;
            op_rem   <= in_rem;
            op_word  <= in_word;
            rsp_tag  <= in_tag;
        end else if (busy && !last_step) begin
            part_rem <= rem_step;
            quot_q   <= {quot_q[XLEN-1:0], ~rem_step[XLEN]};
        end else if (busy) begin
            rsp_data <= res_out;
        end
    end

    // a running divide never shows a response
    a_busy_excl: assert property (@(posedge clk) disable iff (rst)
        busy |-> !rsp_valid);

    // no new request latched while a divide runs
    a_busy_hold: assert property (@(posedge clk) disable iff (rst)
        busy |=> $stable(rsp_tag) && $stable(dvs_mag));

    // fixed latency, special cases included
    a_latency: assert property (@(posedge clk) disable iff (rst)
        accept |=> !rsp_valid [*DIV_CYCLES] ##1 rsp_valid);

endmodule

// File: div_req_fifo.sv
`timescale 1ns/1ps

module div_req_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = div_pkg::REQ_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // storage, no reset needed on payload
    payload_t mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign full  = int'(count) == DEPTH;
    assign empty = count == '0;

    // a full queue still takes a write when the head leaves
    assign in_ready  = !full || out_ready;
    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // pointers meet only when full or empty, so no live entry is overwritten
    a_no_wr_full: assert property (@(posedge clk) disable iff (rst)
        (wr_ptr == rd_ptr) == (full || empty));

    // occupancy stays in range
    a_count_range: assert property (@(posedge clk) disable iff (rst)
        int'(count) <= DEPTH);

endmodule

// File: div_issue.sv
`timescale 1ns/1ps

module div_issue (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic [2:0]                req_funct3,
    input  logic                      req_word,
    input  logic [div_pkg::TAG_W-1:0] req_tag,
    input  logic [div_pkg::XLEN-1:0]  req_rs1,
    input  logic [div_pkg::XLEN-1:0]  req_rs2,
    output logic                      iss_valid,
    input  logic                      iss_ready,
    output logic                      iss_signed,
    output logic                      iss_rem,
    output logic                      iss_word,
    output logic [div_pkg::TAG_W-1:0] iss_tag,
    output logic [div_pkg::XLEN-1:0]  iss_rs1,
    output logic [div_pkg::XLEN-1:0]  iss_rs2
);
    import div_pkg::*;

    logic accept;
    logic is_signed_d;
    logic want_rem_d;

    // DIV and REM are the signed pair
    assign is_signed_d = (req_funct3 == FUNCT3_DIV) || (req_funct3 == FUNCT3_REM);
    assign want_rem_d  = (req_funct3 == FUNCT3_REM) || (req_funct3 == FUNCT3_REMU);

    // empty, or draining this cycle
    assign req_ready = !iss_valid || iss_ready;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            iss_valid <= 1'b0;
        end else if (accept) begin
            iss_valid <= 1'b1;
        end else if (iss_ready) begin
            iss_valid <= 1'b0;
        end
    end

    // payload, loaded on accept only
    always_ff @(posedge clk) begin
        if (accept) begin
            iss_signed <= is_signed_d;
            iss_rem    <= want_rem_d;
            iss_word   <= req_word;
            iss_tag    <= req_tag;
            iss_rs1    <= req_rs1;
            iss_rs2    <= req_rs2;
        end
    end

    // only the divide group reaches this unit
    a_funct3_div: assert property (@(posedge clk) disable iff (rst)
        accept |-> req_funct3[2]);

    // downstream stall holds the register
    a_hold_stall: assert property (@(posedge clk) disable iff (rst)
        iss_valid && !iss_ready |=> iss_valid && $stable(iss_tag) && $stable(iss_rs1)
            && $stable(iss_rs2) && $stable({iss_signed, iss_rem, iss_word}));

endmodule

// File: div_pkg.sv
package div_pkg;

    // operand and result width
    localparam int XLEN = 64;

    // destination register tag width
    localparam int TAG_W = 5;

    // accepting edge to rsp_valid, fixed for every op
    localparam int DIV_CYCLES = 66;

    // request queue entries
    localparam int REQ_DEPTH = 4;

    // funct3 of the M extension divide group
    localparam logic [2:0] FUNCT3_DIV  = 3'b100;
    localparam logic [2:0] FUNCT3_DIVU = 3'b101;
    localparam logic [2:0] FUNCT3_REM  = 3'b110;
    localparam logic [2:0] FUNCT3_REMU = 3'b111;

    // one decoded divide request
    typedef struct packed {
        // signed operands
        logic             is_signed;
        // return remainder instead of quotient
        logic             want_rem;
        // 32-bit word form
        logic             is_word;
        logic [TAG_W-1:0] tag;
        // dividend
        logic [XLEN-1:0]  rs1;
        // divisor
        logic [XLEN-1:0]  rs2;
    } div_req_t;

endpackage
